/* common/armCtrlPkg.sv */
package armCtrlPkg;

  // ==========================================================
  // Instruction field encodings
  // ==========================================================

  // Bits 27:26 of the instruction word
  localparam logic [1:0] ClassDp     = 2'b00;
  localparam logic [1:0] ClassMem    = 2'b01;
  localparam logic [1:0] ClassBranch = 2'b10;  // 2'b11 is reserved here

  // Data-processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    OpAnd = 4'h0, OpEor = 4'h1, OpSub = 4'h2, OpRsb = 4'h3,
    OpAdd = 4'h4, OpAdc = 4'h5, OpSbc = 4'h6, OpRsc = 4'h7,
    OpTst = 4'h8, OpTeq = 4'h9, OpCmp = 4'ha, OpCmn = 4'hb,
    OpOrr = 4'hc, OpMov = 4'hd, OpBic = 4'he, OpMvn = 4'hf
  } aluOpE;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    CondEq = 4'h0, CondNe = 4'h1, CondCs = 4'h2, CondCc = 4'h3,
    CondMi = 4'h4, CondPl = 4'h5, CondVs = 4'h6, CondVc = 4'h7,
    CondHi = 4'h8, CondLs = 4'h9, CondGe = 4'ha, CondLt = 4'hb,
    CondGt = 4'hc, CondLe = 4'hd, CondAl = 4'he, CondNv = 4'hf
  } condE;

  // Logical opcodes only touch N and Z (C comes from the shifter, not modelled)
  function automatic logic isLogical(aluOpE op);
    return op inside {OpAnd, OpEor, OpTst, OpTeq, OpOrr, OpMov, OpBic, OpMvn};
  endfunction

  // Data-processing view of the word
  typedef struct packed {
    condE        cond;
    logic [1:0]  opClass;
    logic        I;         // Immediate operand2
    aluOpE       opcode;
    logic        S;         // Set flags
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpFieldsT;

  // Load/store view of the same word
  typedef struct packed {
    condE        cond;
    logic [1:0]  opClass;
    logic        I;         // Register offset when set
    logic        P, U, B, W, L;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memFieldsT;

  typedef union packed {
    dpFieldsT  dp;
    memFieldsT mem;
  } instrU;

  // ==========================================================
  // Control bundles
  // ==========================================================

  typedef struct packed {
    logic n, z, c, v;
  } flagsT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;     // Immediate into ALU B
    logic       rType;      // Register operand2 or offset
  } decCtrlT;

  typedef struct packed {
    aluOpE      aluControl;
    logic [1:0] flagWrite;  // [1] NZ, [0] CV
    logic       branch, memWrite, regWrite, memtoReg, pcSrc, byteAccess;
  } exCtrlT;

  typedef struct packed {
    logic       memWrite, memtoReg, regWrite, pcSrc;
    logic [3:0] byteMask;
  } memCtrlT;

  typedef struct packed {
    logic       memtoReg, regWrite, pcSrc, loadByte;
    logic [1:0] byteOffset;
  } wbCtrlT;

endpackage

/* src/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
  input  armCtrlPkg::instrU   instrD,
  output armCtrlPkg::decCtrlT decCtrlD,  // Datapath selects, used in D
  output armCtrlPkg::exCtrlT  exCtrlD    // Travels on to E
);
  import armCtrlPkg::*;

  logic isCompare;  // TST, TEQ, CMP, CMN
  logic rdIsPc;

  assign isCompare = instrD.dp.opcode inside {OpTst, OpTeq, OpCmp, OpCmn};
  assign rdIsPc    = (instrD.dp.rd == 4'hf);

  always_comb begin
    decCtrlD = '0;  // Reserved class decodes to a bubble
    exCtrlD  = '0;
    case (instrD.dp.opClass)
      ClassDp: begin
        decCtrlD.aluSrc    = instrD.dp.I;   // Rotated imm8
        decCtrlD.rType     = ~instrD.dp.I;  // Shifted Rm
        exCtrlD.aluControl = instrD.dp.opcode;
        if (instrD.dp.S) begin
          // Logical ops leave C and V alone
          if (isLogical(instrD.dp.opcode)) begin
            exCtrlD.flagWrite = 2'b10;
          end else begin
            exCtrlD.flagWrite = 2'b11;
          end
        end
        exCtrlD.regWrite = ~isCompare;  // Compares only set flags
        exCtrlD.pcSrc    = rdIsPc & ~isCompare;  // Write to R15 redirects fetch
      end
      ClassMem: begin
        // Stores read Rd as the data source
        decCtrlD.regSrc = {~instrD.mem.L, 1'b0};
        decCtrlD.immSrc = 2'b01;          // imm12 offset
        decCtrlD.aluSrc = ~instrD.mem.I;  // I clear means immediate offset here
        decCtrlD.rType  = instrD.mem.I;
        // U picks offset direction
        if (instrD.mem.U) begin
          exCtrlD.aluControl = OpAdd;
        end else begin
          exCtrlD.aluControl = OpSub;
        end
        exCtrlD.memWrite   = ~instrD.mem.L;
        exCtrlD.regWrite   = instrD.mem.L;
        exCtrlD.memtoReg   = instrD.mem.L;
        exCtrlD.byteAccess = instrD.mem.B;
      end
      ClassBranch: begin
        decCtrlD.regSrc    = 2'b01;  // PC as source A
        decCtrlD.immSrc    = 2'b10;  // imm24, shifted left by 2
        decCtrlD.aluSrc    = 1'b1;
        exCtrlD.aluControl = OpAdd;  // PC plus offset
        exCtrlD.branch     = 1'b1;
        exCtrlD.pcSrc      = 1'b1;
      end
      default: begin
        decCtrlD = '0;
        exCtrlD  = '0;
      end
    endcase
  end

  // Reserved class only shows up in the NV space
  always_comb begin
    assert final ($isunknown(instrD) || instrD.dp.opClass != 2'b11 ||
                  instrD.dp.cond == CondNv)
      else $error("instrDecoder: reserved class with condition %0h", instrD.dp.cond);
  end

endmodule

/* src/condUnit.sv */
`timescale 1ns/1ps

module condUnit (
  input  armCtrlPkg::condE  condE,       // Condition field of the E instruction
  input  armCtrlPkg::flagsT flagsE,      // Current flags, already forwarded
  input  armCtrlPkg::flagsT aluFlagsE,   // Fresh flags from the ALU
  input  logic [1:0]        flagWriteE,  // [1] NZ, [0] CV
  output logic              condExE,
  output armCtrlPkg::flagsT flagsNextE
);
  import armCtrlPkg::*;

  logic nEqV;  // Signed greater-or-equal

  assign nEqV = (flagsE.n == flagsE.v);

  // Condition check
  always_comb begin
    case (condE)
      CondEq:  condExE = flagsE.z;
      CondNe:  condExE = ~flagsE.z;
      CondCs:  condExE = flagsE.c;
      CondCc:  condExE = ~flagsE.c;
      CondMi:  condExE = flagsE.n;
      CondPl:  condExE = ~flagsE.n;
      CondVs:  condExE = flagsE.v;
      CondVc:  condExE = ~flagsE.v;
      CondHi:  condExE = flagsE.c & ~flagsE.z;   // Unsigned higher
      CondLs:  condExE = ~flagsE.c | flagsE.z;   // Unsigned lower or same
      CondGe:  condExE = nEqV;
      CondLt:  condExE = ~nEqV;
      CondGt:  condExE = ~flagsE.z & nEqV;
      CondLe:  condExE = flagsE.z | ~nEqV;
      CondAl:  condExE = 1'b1;
      default: condExE = 1'b0;                   // NV never executes
    endcase
  end

  // Next flags, merged per pair from the ALU
  always_comb begin
    flagsNextE = flagsE;
    if (flagWriteE[1]) begin
      flagsNextE.n = aluFlagsE.n;
      flagsNextE.z = aluFlagsE.z;
    end
    if (flagWriteE[0]) begin
      flagsNextE.c = aluFlagsE.c;
      flagsNextE.v = aluFlagsE.v;
    end
  end

endmodule

/* src/flagsReg.sv */
`timescale 1ns/1ps

module flagsReg (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stallE, stallM, stallW,
  input  logic              flushM, flushW,
  input  logic              setFlagsE,   // Already gated by the condition
  input  armCtrlPkg::flagsT flagsNextE,
  output armCtrlPkg::flagsT flagsE       // Forwarded view for E
);
  import armCtrlPkg::*;

  flagsT flagsM, flagsW;  // Pending values, travel with their instruction
  flagsT flagsArch;       // Committed NZCV
  logic  setFlagsM, setFlagsW;

  // M and W copies follow the stage register rules
  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      setFlagsM <= 1'b0;
    end else if (!stallM) begin
      setFlagsM <= setFlagsE & ~stallE;  // Held E sends a bubble
      flagsM    <= flagsNextE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      setFlagsW <= 1'b0;
    end else if (!stallW) begin
      setFlagsW <= setFlagsM & ~stallM;
      flagsW    <= flagsM;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsArch <= '0;
    end else if (setFlagsW && !stallW) begin
      flagsArch <= flagsW;  // Commit as W retires
    end
  end

  // Youngest pending update wins
  assign flagsE = setFlagsM ? flagsM : (setFlagsW ? flagsW : flagsArch);

  assert property (@(posedge clk) !rstN |=> flagsE == 4'b0000)
    else $error("flagsReg: flags not clear after reset");

endmodule

/* src/memByteMask.sv */
`timescale 1ns/1ps

module memByteMask (
  input  logic [1:0] addrLowE,     // ALU result bits 1:0
  input  logic       byteAccessE,  // B bit of the E instruction
  output logic [3:0] byteMaskE,    // One bit per byte lane
  output logic [1:0] byteOffsetE   // Lane for load-byte alignment in W
);

  // Little endian lanes, lane 0 is bits 7:0
  always_comb begin
    if (byteAccessE) begin
      case (addrLowE)
        2'd0:    byteMaskE = 4'b0001;
        2'd1:    byteMaskE = 4'b0010;
        2'd2:    byteMaskE = 4'b0100;
        default: byteMaskE = 4'b1000;
      endcase
    end else begin
      // Word access, low bits assumed zero
      byteMaskE = 4'b1111;
    end
  end

  // W picks the loaded byte from this lane
  assign byteOffsetE = addrLowE;

endmodule

/* pipeControl/pipeControl.sv */
`timescale 1ns/1ps

module pipeControl (
  input  logic                clk,
  input  logic                rstN,
  input  armCtrlPkg::exCtrlT  exCtrlD,       // From decoder
  input  armCtrlPkg::condE    condD,
  input  logic                stallE, stallM, stallW,
  input  logic                flushE, flushM, flushW,
  input  logic                condExE,       // From condUnit
  input  logic [3:0]          byteMaskE,     // From memByteMask
  input  logic [1:0]          byteOffsetE,
  output armCtrlPkg::exCtrlT  exCtrlE,
  output armCtrlPkg::condE    condE,
  output armCtrlPkg::aluOpE   aluControlE,
  output logic                branchTakenE,
  output logic                memtoRegE,
  output logic                setFlagsE,
  output armCtrlPkg::memCtrlT memCtrlM,
  output armCtrlPkg::wbCtrlT  wbCtrlW,
  output logic                pcWrPending    // Redirect in flight
);
  import armCtrlPkg::*;

  logic    issueE;        // E instruction executes and moves on
  logic    memAccessE;
  memCtrlT memCtrlNextE;
  logic    loadByteNextE;
  logic    loadByteM;
  logic [1:0] byteOffsetNextE, byteOffsetM;
  wbCtrlT  wbCtrlNextM;

  // ==========================================================
  // Execute
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      exCtrlE <= '0;       // Bubble
      condE   <= CondEq;
    end else if (!stallE) begin
      exCtrlE <= exCtrlD;
      condE   <= condD;
    end
  end

  assign aluControlE  = exCtrlE.aluControl;
  assign branchTakenE = exCtrlE.branch & condExE;
  assign memtoRegE    = exCtrlE.memtoReg & condExE;  // No load when the condition fails
  assign setFlagsE    = (exCtrlE.flagWrite != 2'b00) & condExE;

  // A held E must not repeat itself in M
  assign issueE     = condExE & ~stallE;
  assign memAccessE = exCtrlE.memWrite | exCtrlE.memtoReg;

  always_comb begin
    memCtrlNextE.memWrite = exCtrlE.memWrite & issueE;
    memCtrlNextE.memtoReg = exCtrlE.memtoReg & issueE;
    memCtrlNextE.regWrite = exCtrlE.regWrite & issueE;
    memCtrlNextE.pcSrc    = exCtrlE.pcSrc & issueE;
    // Lanes only mean something for a memory access
    memCtrlNextE.byteMask = (memAccessE & issueE) ? byteMaskE : 4'b0000;
  end

  assign loadByteNextE   = exCtrlE.byteAccess & exCtrlE.memtoReg & issueE;
  assign byteOffsetNextE = loadByteNextE ? byteOffsetE : 2'b00;

  // ==========================================================
  // Memory
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!rstN || flushM) begin
      memCtrlM    <= '0;
      loadByteM   <= 1'b0;
      byteOffsetM <= 2'b00;
    end else if (!stallM) begin
      memCtrlM    <= memCtrlNextE;
      loadByteM   <= loadByteNextE;
      byteOffsetM <= byteOffsetNextE;
    end
  end

  // Held M sends a bubble on to W
  always_comb begin
    wbCtrlNextM = '0;
    if (!stallM) begin
      wbCtrlNextM.memtoReg   = memCtrlM.memtoReg;
      wbCtrlNextM.regWrite   = memCtrlM.regWrite;
      wbCtrlNextM.pcSrc      = memCtrlM.pcSrc;
      wbCtrlNextM.loadByte   = loadByteM;
      wbCtrlNextM.byteOffset = byteOffsetM;
    end
  end

  // ==========================================================
  // Writeback
  // ==========================================================

  always_ff @(posedge clk) begin
    if (!rstN || flushW) begin
      wbCtrlW <= '0;
    end else if (!stallW) begin
      wbCtrlW <= wbCtrlNextM;
    end
  end

  // Ungated E copy keeps the hazard logic waiting on the condition
  assign pcWrPending = exCtrlD.pcSrc | exCtrlE.pcSrc | memCtrlM.pcSrc;

  // No decoded word both loads and stores
  assert property (@(posedge clk) disable iff (!rstN)
                   !(memCtrlM.memWrite && memCtrlM.memtoReg))
    else $error("pipeControl: memWrite and memtoReg both set in M");

  // A taken branch carries its redirect into M
  assert property (@(posedge clk) disable iff (!rstN)
                   (branchTakenE && !stallE && !stallM && !flushM) |=> memCtrlM.pcSrc)
    else $error("pipeControl: taken branch lost its redirect before M");

endmodule

/* src/armController.sv */
`timescale 1ns/1ps

module armController (
  input  logic                clk,
  input  logic                rstN,
  input  armCtrlPkg::instrU   instrD,
  input  armCtrlPkg::flagsT   aluFlagsE,
  input  logic [1:0]          addrLowE,
  input  logic                stallD, stallE, stallM, stallW,  // From hazard unit
  input  logic                flushE, flushM, flushW,
  output armCtrlPkg::decCtrlT decCtrlD,
  output armCtrlPkg::aluOpE   aluControlE,
  output armCtrlPkg::flagsT   flagsE,
  output logic                branchTakenE,
  output logic                memtoRegE,
  output armCtrlPkg::memCtrlT memCtrlM,
  output armCtrlPkg::wbCtrlT  wbCtrlW,
  output logic                pcWrPending
);
  import armCtrlPkg::*;

  exCtrlT           exCtrlD, exCtrlE;
  armCtrlPkg::condE condE;
  flagsT            flagsNextE;
  logic             condExE, setFlagsE;
  logic [3:0]       byteMaskE;
  logic [1:0]       byteOffsetE;

  instrDecoder dec0 (.instrD(instrD), .decCtrlD(decCtrlD), .exCtrlD(exCtrlD));

  // D holds in the fetch/decode registers, outside this block
  pipeControl pipe0 (
    .clk(clk), .rstN(rstN), .exCtrlD(exCtrlD), .condD(instrD.dp.cond),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushM(flushM), .flushW(flushW),
    .condExE(condExE), .byteMaskE(byteMaskE), .byteOffsetE(byteOffsetE),
    .exCtrlE(exCtrlE), .condE(condE), .aluControlE(aluControlE),
    .branchTakenE(branchTakenE), .memtoRegE(memtoRegE), .setFlagsE(setFlagsE),
    .memCtrlM(memCtrlM), .wbCtrlW(wbCtrlW), .pcWrPending(pcWrPending)
  );

  condUnit cond0 (
    .condE(condE), .flagsE(flagsE), .aluFlagsE(aluFlagsE),
    .flagWriteE(exCtrlE.flagWrite), .condExE(condExE), .flagsNextE(flagsNextE)
  );

  flagsReg flags0 (
    .clk(clk), .rstN(rstN), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushM(flushM), .flushW(flushW), .setFlagsE(setFlagsE),
    .flagsNextE(flagsNextE), .flagsE(flagsE)
  );

  memByteMask mask0 (
    .addrLowE(addrLowE), .byteAccessE(exCtrlE.byteAccess),
    .byteMaskE(byteMaskE), .byteOffsetE(byteOffsetE)
  );

endmodule

/* verif/tbTests.svh */
// ============================================================
// Shared sequences
// ============================================================

// Selects follow the usual single-cycle ARM datapath
task automatic decodeCase(string name, instrU w, decCtrlT expDec, aluOpE expAlu);
  step(w);
  checkDec({name, " decCtrlD"}, expDec, decCtrlD);
  step(NopWord);  // Now in E
  checkAluOp({name, " aluControlE"}, expAlu, aluControlE);
endtask

task automatic condCase(string name, instrU w, logic expTaken, memCtrlT expM);
  step(w);
  step(NopWord);
  checkBit({name, " branchTakenE"}, expTaken, branchTakenE);
  step(NopWord);
  checkMem({name, " memCtrlM"}, expM, memCtrlM);
endtask

// CMP writes all four flags and drains until committed
task automatic setFlags(flagsT f);
  step(dpWord(CondAl, 1'b1, OpCmp, 1'b1, 4'd0));
  stepWith(NopWord, f, 2'b00);
  repeat (3) step(NopWord);
  checkFlags("flagsE after CMP", f, flagsE);
endtask

// ============================================================
// Tests
// ============================================================

task automatic testReset();
  int errStart;
  errStart = errorCount;
  step(dpWord(CondAl, 1'b1, OpAdd, 1'b1, randRd()));  // ADDS
  stepWith(brWord(CondAl), 4'b1111, 2'b00);
  step(brWord(CondAl));  // Live work in E and M when reset hits
  checkFlags("flagsE before reset", 4'b1111, flagsE);
  @(posedge clk);
  rstN <= 1'b0;
  repeat (2) @(posedge clk);
  rstN   <= 1'b1;
  instrD <= NopWord;
  @(negedge clk);
  checkDec("decCtrlD", '0, decCtrlD);
  checkAluOp("aluControlE", OpAnd, aluControlE);
  checkFlags("flagsE", 4'b0000, flagsE);
  checkBit("branchTakenE", 1'b0, branchTakenE);
  checkBit("memtoRegE", 1'b0, memtoRegE);
  checkMem("memCtrlM", '0, memCtrlM);
  checkWb("wbCtrlW", '0, wbCtrlW);
  checkBit("pcWrPending", 1'b0, pcWrPending);
  endTest("reset", errStart);
endtask

task automatic testDecode();
  int errStart;
  errStart = errorCount;
  decodeCase("sub imm", dpWord(CondAl, 1'b1, OpSub, 1'b0, randRd()),
             decCtrlT'{2'b00, 2'b00, 1'b1, 1'b0}, OpSub);
  decodeCase("eor reg", dpWord(CondAl, 1'b0, OpEor, 1'b0, randRd()),
             decCtrlT'{2'b00, 2'b00, 1'b0, 1'b1}, OpEor);
  decodeCase("ldr up", memWord(CondAl, 1'b1, 1'b0, 1'b1, randRd()),
             decCtrlT'{2'b00, 2'b01, 1'b1, 1'b0}, OpAdd);
  decodeCase("str down", memWord(CondAl, 1'b0, 1'b0, 1'b0, randRd()),
             decCtrlT'{2'b10, 2'b01, 1'b1, 1'b0}, OpSub);
  decodeCase("b", brWord(CondAl), decCtrlT'{2'b01, 2'b10, 1'b1, 1'b0}, OpAdd);
  checkBit("b branchTakenE", 1'b1, branchTakenE);  // B still in E
  checkBit("b pcWrPending", 1'b1, pcWrPending);
  endTest("decode", errStart);
endtask

task automatic testPipeline();
  int    errStart;
  int    k;
  instrU add;
  errStart = errorCount;
  add = dpWord(CondAl, 1'b1, OpAdd, 1'b0, randRd());
  step(add);
  step(NopWord);  // E
  step(NopWord);  // M
  checkBit("memCtrlM.regWrite", 1'b1, memCtrlM.regWrite);
  checkBit("wbCtrlW.regWrite early", 1'b0, wbCtrlW.regWrite);
  step(NopWord);  // W
  checkBit("wbCtrlW.regWrite", 1'b1, wbCtrlW.regWrite);
  // Same ADD held in M for k cycles
  k = 1 + int'($urandom % 3);
  step(add);
  step(NopWord);
  @(posedge clk);
  stallM <= 1'b1;
  @(negedge clk);
  checkBit("memCtrlM.regWrite", 1'b1, memCtrlM.regWrite);
  for (int i = 1; i <= k; i++) begin
    @(posedge clk);
    if (i == k) begin
      stallM <= 1'b0;  // Last held edge
    end
    @(negedge clk);
    checkBit("memCtrlM.regWrite held", 1'b1, memCtrlM.regWrite);
    checkBit("wbCtrlW.regWrite stalled", 1'b0, wbCtrlW.regWrite);
  end
  step(NopWord);
  checkBit("wbCtrlW.regWrite after stall", 1'b1, wbCtrlW.regWrite);
  endTest("pipeline", errStart);
endtask

task automatic testCondExec();
  int errStart;
  errStart = errorCount;
  setFlags(4'b0100);  // Z only
  condCase("addne", dpWord(CondNe, 1'b1, OpAdd, 1'b0, randRd()), 1'b0, '0);
  condCase("strne", memWord(CondNe, 1'b1, 1'b0, 1'b0, randRd()), 1'b0, '0);
  condCase("bne", brWord(CondNe), 1'b0, '0);
  condCase("addeq", dpWord(CondEq, 1'b1, OpAdd, 1'b0, randRd()), 1'b0,
           memCtrlT'{1'b0, 1'b0, 1'b1, 1'b0, 4'b0000});
  condCase("bal", brWord(CondAl), 1'b1, memCtrlT'{1'b0, 1'b0, 1'b0, 1'b1, 4'b0000});
  condCase("stral", memWord(CondAl, 1'b1, 1'b0, 1'b0, randRd()), 1'b0,
           memCtrlT'{1'b1, 1'b0, 1'b0, 1'b0, 4'b1111});
  endTest("condexec", errStart);
endtask

task automatic testFlags();
  int    errStart;
  instrU cmp, addeq;
  errStart = errorCount;
  cmp   = dpWord(CondAl, 1'b1, OpCmp, 1'b1, 4'd0);
  addeq = dpWord(CondEq, 1'b1, OpAdd, 1'b0, randRd());
  setFlags(4'b0000);
  // ADDEQ right behind a Z-setting CMP sees Z through M
  step(cmp);
  stepWith(addeq, 4'b0100, 2'b00);
  step(NopWord);
  checkFlags("flagsE from M", 4'b0100, flagsE);
  step(NopWord);
  checkBit("addeq regWrite after M fwd", 1'b1, memCtrlM.regWrite);
  repeat (2) step(NopWord);
  // Register holds Z now and CMP clears it so ADDEQ fails
  step(cmp);
  stepWith(addeq, 4'b0000, 2'b00);
  step(NopWord);
  checkFlags("flagsE cleared from M", 4'b0000, flagsE);
  step(NopWord);
  checkBit("addeq regWrite after clear", 1'b0, memCtrlM.regWrite);
  repeat (2) step(NopWord);
  // One gap lets the update come from W
  step(cmp);
  stepWith(NopWord, 4'b0100, 2'b00);
  step(addeq);
  step(NopWord);
  checkFlags("flagsE from W", 4'b0100, flagsE);
  step(NopWord);
  checkBit("addeq regWrite after W fwd", 1'b1, memCtrlM.regWrite);
  // ANDS writes N and Z only
  setFlags(4'b1111);
  step(dpWord(CondAl, 1'b1, OpAnd, 1'b1, randRd()));
  stepWith(NopWord, 4'b0100, 2'b00);
  step(NopWord);
  checkFlags("flagsE after ANDS", 4'b0111, flagsE);
  endTest("flags", errStart);
endtask

task automatic testByteMask();
  int         errStart;
  logic [1:0] addr;
  logic [3:0] lane;
  errStart = errorCount;
  for (int i = 0; i < 4; i++) begin
    lane = 4'b0001 << i;
    step(memWord(CondAl, 1'b1, 1'b1, 1'b0, randRd()));  // STRB
    stepWith(NopWord, 4'b0000, 2'(i));
    step(NopWord);
    checkMem("strb memCtrlM", memCtrlT'{1'b1, 1'b0, 1'b0, 1'b0, lane}, memCtrlM);
  end
  step(memWord(CondAl, 1'b1, 1'b0, 1'b0, randRd()));  // Word-aligned STR
  step(NopWord);
  step(NopWord);
  checkMem("str memCtrlM", memCtrlT'{1'b1, 1'b0, 1'b0, 1'b0, 4'b1111}, memCtrlM);
  addr = 2'($urandom);
  lane = 4'b0001 << addr;
  step(memWord(CondAl, 1'b1, 1'b1, 1'b1, randRd()));  // LDRB
  stepWith(NopWord, 4'b0000, addr);
  checkBit("ldrb memtoRegE", 1'b1, memtoRegE);
  step(NopWord);
  checkMem("ldrb memCtrlM", memCtrlT'{1'b0, 1'b1, 1'b1, 1'b0, lane}, memCtrlM);
  step(NopWord);
  checkWb("ldrb wbCtrlW", wbCtrlT'{1'b1, 1'b1, 1'b0, 1'b1, addr}, wbCtrlW);
  endTest("bytemask", errStart);
endtask

task automatic testFlush();
  int errStart;
  errStart = errorCount;
  @(posedge clk);
  instrD <= memWord(CondAl, 1'b1, 1'b0, 1'b0, randRd());  // STR in D
  flushE <= 1'b1;  // E takes a bubble instead
  @(posedge clk);
  instrD <= NopWord;
  flushE <= 1'b0;
  @(negedge clk);
  step(NopWord);  // Store would be in M here
  checkMem("flushed memCtrlM", '0, memCtrlM);
  endTest("flush", errStart);
endtask

/* verif/tbArmController.sv */
`timescale 1ns/1ps

module tbArmController;
  import armCtrlPkg::*;

  localparam logic [31:0] NopWord = 32'hfc00_0000;  // NV with reserved class, decodes to a bubble
  // Start-up, reset, decode, pipeline, cond, flags, byte masks, flush
  localparam int TestCycles    = 3 + 7 + 10 + 11 + 23 + 30 + 19 + 3;
  localparam int TimeoutCycles = TestCycles * 3 / 2;

  logic       clk, rstN;
  instrU      instrD;
  flagsT      aluFlagsE;
  logic [1:0] addrLowE;
  logic       stallD, stallE, stallM, stallW;
  logic       flushE, flushM, flushW;
  decCtrlT    decCtrlD;
  aluOpE      aluControlE;
  flagsT      flagsE;
  logic       branchTakenE, memtoRegE, pcWrPending;
  memCtrlT    memCtrlM;
  wbCtrlT     wbCtrlW;

  int errorCount = 0;
  int testCount  = 0;
  int failCount  = 0;
  int cycleCount = 0;

  armController dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // Watchdog
  initial begin
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: tests still running after %0d cycles", TimeoutCycles);
    $display("Done: errors found");
    $finish;
  end

  // ============================================================
  // Instruction words
  // ============================================================

  function automatic logic [3:0] randRd();
    return 4'($urandom % 15);  // Any register but PC
  endfunction

  function automatic instrU dpWord(condE c, logic imm, aluOpE op, logic s, logic [3:0] rd);
    instrU w;
    w             = '0;
    w.dp.cond     = c;
    w.dp.opClass  = ClassDp;
    w.dp.I        = imm;
    w.dp.opcode   = op;
    w.dp.S        = s;
    w.dp.rn       = 4'($urandom);
    w.dp.rd       = rd;
    w.dp.operand2 = 12'($urandom);
    return w;
  endfunction

  // Pre-indexed, immediate offset, no writeback
  function automatic instrU memWord(condE c, logic u, logic b, logic l, logic [3:0] rd);
    instrU w;
    w             = '0;
    w.mem.cond    = c;
    w.mem.opClass = ClassMem;
    w.mem.P       = 1'b1;
    w.mem.U       = u;
    w.mem.B       = b;
    w.mem.L       = l;
    w.mem.rn      = 4'($urandom);
    w.mem.rd      = rd;
    w.mem.offset  = 12'($urandom);
    return w;
  endfunction

  function automatic instrU brWord(condE c);
    return {c, ClassBranch, 2'b10, 24'($urandom)};  // B without link
  endfunction

  // ============================================================
  // Stimulus and compare
  // ============================================================

  // New word into D; flags and address belong to the word entering E at this edge
  task automatic stepWith(instrU nextD, flagsT aluF, logic [1:0] addr);
    @(posedge clk);
    instrD    <= nextD;
    aluFlagsE <= aluF;
    addrLowE  <= addr;
    @(negedge clk);  // Outputs settled here
  endtask

  task automatic step(instrU nextD);
    stepWith(nextD, 4'b0000, 2'b00);
  endtask

  task automatic checkDec(string name, decCtrlT exp, decCtrlT act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errorCount++;
    end
  endtask

  task automatic checkMem(string name, memCtrlT exp, memCtrlT act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errorCount++;
    end
  endtask

  task automatic checkWb(string name, wbCtrlT exp, wbCtrlT act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errorCount++;
    end
  endtask

  task automatic checkFlags(string name, flagsT exp, flagsT act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);  // NZCV
      errorCount++;
    end
  endtask

  task automatic checkAluOp(string name, aluOpE exp, aluOpE act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errorCount++;
    end
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      errorCount++;
    end
  endtask

  task automatic endTest(string name, int errStart);
    testCount++;
    if (errorCount == errStart) begin
      $display("Test %s: passed at %0t ns", name, $time);
    end else begin
      failCount++;
      $display("Test %s: failed with %0d errors", name, errorCount - errStart);
    end
  endtask

  `include "tbTests.svh"

  initial begin
    void'($urandom(32'h5591be85));  // Single seed for the run
    rstN      <= 1'b0;
    instrD    <= NopWord;
    aluFlagsE <= 4'b0000;
    addrLowE  <= 2'b00;
    {stallD, stallE, stallM, stallW} <= 4'b0000;
    {flushE, flushM, flushW}         <= 3'b000;
    repeat (2) @(posedge clk);  // Two reset cycles
    rstN <= 1'b1;
    @(negedge clk);
    testReset();
    testDecode();
    testPipeline();
    testCondExec();
    testFlags();
    testByteMask();
    testFlush();
    $display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+verif
common/armCtrlPkg.sv
src/instrDecoder.sv
src/condUnit.sv
src/flagsReg.sv
src/memByteMask.sv
pipeControl/pipeControl.sv
src/armController.sv
verif/tbArmController.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbArmController
FLIST     = flist.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)
